/* include/gate_settings.svh */
// widths and depth shared by the package and the permit FIFO
// a permit length is a beat count of 1 to 2**GATE_LEN_W-1, zero is illegal
// the FIFO depth is 2**GATE_FIFO_AW and must stay a power of two

`ifndef GATE_SETTINGS_SVH
`define GATE_SETTINGS_SVH

// data word on every stream
`define GATE_DATA_W  32

// permit fields
`define GATE_LEN_W   8
`define GATE_USER_W  4

// permit FIFO address bits
`define GATE_FIFO_AW 2

`endif

/* hdl/gate_pkg.sv */
// types shared by the gate, the permit FIFO and the arbiter
// field order inside the structs sets the bit layout on every port

`include "gate_settings.svh"

package gate_pkg;

    // ------------------------------------------------------------
    // plain widths
    typedef logic [`GATE_DATA_W-1:0] data_t;
    typedef logic [`GATE_LEN_W-1:0]  len_t;
    typedef logic [`GATE_USER_W-1:0] user_t;

    // ------------------------------------------------------------
    // 34-bit stream beat
    typedef struct packed {
        logic  first;
        logic  last;
        data_t data;
    } beat_t;

    // 14-bit permit record
    typedef struct packed {
        logic  first;
        logic  last;
        len_t  len;
        user_t user;
    } permit_t;

    // beat on the shared bus tagged with its channel number in src
    typedef struct packed {
        beat_t beat;
        user_t user;
        logic  src;
    } out_beat_t;

endpackage

/* hdl/permit_fifo.sv */
// synchronous permit FIFO, first-word fall-through
// s_ready drops when all 2**GATE_FIFO_AW entries are used
// a write to an empty FIFO shows up on m_permit one cycle later

`timescale 1ns/1ns

`include "gate_settings.svh"

module permit_fifo (
    input  logic              clk,
    input  logic              reset,

    input  gate_pkg::permit_t s_permit,
    input  logic              s_valid,
    output logic              s_ready,

    output gate_pkg::permit_t m_permit,
    output logic              m_valid,
    input  logic              m_ready
);
    import gate_pkg::*;

    localparam int DEPTH = 1 << `GATE_FIFO_AW;

    permit_t                  mem [DEPTH];
    logic [`GATE_FIFO_AW-1:0] wr_ptr;
    logic [`GATE_FIFO_AW-1:0] rd_ptr;
    logic [`GATE_FIFO_AW:0]   count;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en = s_valid && s_ready;
    assign rd_en = m_valid && m_ready;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_permit;
        end
    end

    assign s_ready  = (count != (`GATE_FIFO_AW+1)'(DEPTH));
    assign m_valid  = (count != '0);
    assign m_permit = mem[rd_ptr];

endmodule

/* hdl/stream_gate.sv */
// gate that passes one permit's worth of beats per frame
// first/last on the output come from the permit, never from the input
// input beats without first at a frame start are dropped as leftovers
// an early input last turns the rest of the count into padding_data beats
// nothing moves while no permit is present

`timescale 1ns/1ns

module stream_gate (
    input  logic              clk,
    input  logic              reset,

    input  gate_pkg::beat_t   s_beat,
    input  logic              s_valid,
    output logic              s_ready,

    input  gate_pkg::permit_t permit,
    input  logic              permit_valid,
    output logic              permit_ready,

    input  gate_pkg::data_t   padding_data,

    output gate_pkg::beat_t   m_beat,
    output gate_pkg::user_t   m_user,
    output logic              m_valid,
    input  logic              m_ready
);
    import gate_pkg::*;

    // frame state
    logic  busy;
    len_t  remain;
    logic  padding;

    // output register
    beat_t out_beat;
    user_t out_user;
    logic  out_valid;

    // per-cycle decisions
    len_t  cur_left;
    logic  frame_start;
    logic  frame_end;
    logic  skip_sel;
    logic  load_en;
    logic  gen_valid;
    logic  issue;
    beat_t next_beat;

    // ------------------------------------------------------------
    // count and flag decode
    always_comb begin
        frame_start = !busy;
        cur_left    = busy ? remain : permit.len;
        frame_end   = (cur_left == len_t'(1));

        // leftover data waiting at a frame start
        skip_sel    = frame_start && !s_beat.first;

        load_en     = !out_valid || m_ready;
        gen_valid   = permit_valid && (padding || (s_valid && !skip_sel));
        issue       = gen_valid && load_en;

        next_beat.first = frame_start ? permit.first : 1'b0;
        next_beat.last  = frame_end ? permit.last : 1'b0;
        next_beat.data  = padding ? padding_data : s_beat.data;
    end

    // a skipped beat does not wait for the output register
    assign s_ready      = permit_valid && !padding && (skip_sel || load_en);
    assign permit_ready = issue && frame_end;

    // ------------------------------------------------------------
    // frame state
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            remain  <= '0;
            padding <= 1'b0;
        end else if (issue) begin
            if (frame_end) begin
                busy    <= 1'b0;
                remain  <= '0;
                padding <= 1'b0;
            end else begin
                busy   <= 1'b1;
                remain <= cur_left - 1'b1;
                // input ran out before the count
                if (!padding && s_beat.last) begin
                    padding <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load_en) begin
            out_valid <= gen_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_beat <= next_beat;
            out_user <= permit.user;
        end
    end

    assign m_beat  = out_beat;
    assign m_user  = out_user;
    assign m_valid = out_valid;

endmodule

/* hdl/bus_arbiter.sv */
// two-channel round-robin arbiter, one grant per frame
// a frame ends on an accepted beat with last set, so a permit with
// last cleared keeps the grant into the next permit of that channel
// mux from the granted channel to m_beat is combinational

`timescale 1ns/1ns

module bus_arbiter (
    input  logic                clk,
    input  logic                reset,

    input  gate_pkg::beat_t     req_beat0,
    input  gate_pkg::beat_t     req_beat1,
    input  gate_pkg::user_t     req_user0,
    input  gate_pkg::user_t     req_user1,
    input  logic                req_valid0,
    input  logic                req_valid1,
    output logic                req_ready0,
    output logic                req_ready1,

    output gate_pkg::out_beat_t m_beat,
    output logic                m_valid,
    input  logic                m_ready
);
    import gate_pkg::*;

    logic  grant;
    logic  mid_frame;
    beat_t sel_beat;
    user_t sel_user;
    logic  sel_valid;
    logic  other_valid;
    logic  accept;
    logic  frame_done;
    logic  idle_swap;

    assign sel_beat    = grant ? req_beat1 : req_beat0;
    assign sel_user    = grant ? req_user1 : req_user0;
    assign sel_valid   = grant ? req_valid1 : req_valid0;
    assign other_valid = grant ? req_valid0 : req_valid1;

    assign accept      = sel_valid && m_ready;
    assign frame_done  = accept && sel_beat.last;
    // hand over only between frames
    assign idle_swap   = !mid_frame && !sel_valid && other_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            grant     <= 1'b0;
            mid_frame <= 1'b0;
        end else begin
            if (accept) begin
                mid_frame <= !sel_beat.last;
            end
            if (frame_done || idle_swap) begin
                grant <= !grant;
            end
        end
    end

    assign req_ready0 = !grant && m_ready;
    assign req_ready1 = grant && m_ready;

    always_comb begin
        m_beat.beat = sel_beat;
        m_beat.user = sel_user;
        m_beat.src  = grant;
    end

    assign m_valid = sel_valid;

endmodule

/* hdl/gate_mux_top.sv */
// two gated input streams merged onto one bus, frame by frame
// each channel has its own permit FIFO of four entries
// padding_data is shared by both gates

`timescale 1ns/1ns

module gate_mux_top (
    input  logic                clk,
    input  logic                reset,

    input  gate_pkg::beat_t     s_beat0,
    input  gate_pkg::beat_t     s_beat1,
    input  logic                s_valid0,
    input  logic                s_valid1,
    output logic                s_ready0,
    output logic                s_ready1,

    input  gate_pkg::permit_t   s_permit0,
    input  gate_pkg::permit_t   s_permit1,
    input  logic                s_permit_valid0,
    input  logic                s_permit_valid1,
    output logic                s_permit_ready0,
    output logic                s_permit_ready1,

    input  gate_pkg::data_t     padding_data,

    output gate_pkg::out_beat_t m_beat,
    output logic                m_valid,
    input  logic                m_ready
);
    import gate_pkg::*;

    // permit FIFO to gate
    permit_t fifo_permit0;
    permit_t fifo_permit1;
    logic    fifo_valid0;
    logic    fifo_valid1;
    logic    pop0;
    logic    pop1;

    // gate to arbiter
    beat_t   gate_beat0;
    beat_t   gate_beat1;
    user_t   gate_user0;
    user_t   gate_user1;
    logic    gate_valid0;
    logic    gate_valid1;
    logic    gate_ready0;
    logic    gate_ready1;

    // ------------------------------------------------------------
    // channel 0
    permit_fifo u_fifo0 (
        .clk      (clk),
        .reset    (reset),
        .s_permit (s_permit0),
        .s_valid  (s_permit_valid0),
        .s_ready  (s_permit_ready0),
        .m_permit (fifo_permit0),
        .m_valid  (fifo_valid0),
        .m_ready  (pop0)
    );

    stream_gate u_gate0 (
        .clk          (clk),
        .reset        (reset),
        .s_beat       (s_beat0),
        .s_valid      (s_valid0),
        .s_ready      (s_ready0),
        .permit       (fifo_permit0),
        .permit_valid (fifo_valid0),
        .permit_ready (pop0),
        .padding_data (padding_data),
        .m_beat       (gate_beat0),
        .m_user       (gate_user0),
        .m_valid      (gate_valid0),
        .m_ready      (gate_ready0)
    );

    // ------------------------------------------------------------
    // channel 1
    permit_fifo u_fifo1 (
        .clk      (clk),
        .reset    (reset),
        .s_permit (s_permit1),
        .s_valid  (s_permit_valid1),
        .s_ready  (s_permit_ready1),
        .m_permit (fifo_permit1),
        .m_valid  (fifo_valid1),
        .m_ready  (pop1)
    );

    stream_gate u_gate1 (
        .clk          (clk),
        .reset        (reset),
        .s_beat       (s_beat1),
        .s_valid      (s_valid1),
        .s_ready      (s_ready1),
        .permit       (fifo_permit1),
        .permit_valid (fifo_valid1),
        .permit_ready (pop1),
        .padding_data (padding_data),
        .m_beat       (gate_beat1),
        .m_user       (gate_user1),
        .m_valid      (gate_valid1),
        .m_ready      (gate_ready1)
    );

    // ------------------------------------------------------------
    // shared bus
    bus_arbiter u_arb (
        .clk        (clk),
        .reset      (reset),
        .req_beat0  (gate_beat0),
        .req_beat1  (gate_beat1),
        .req_user0  (gate_user0),
        .req_user1  (gate_user1),
        .req_valid0 (gate_valid0),
        .req_valid1 (gate_valid1),
        .req_ready0 (gate_ready0),
        .req_ready1 (gate_ready1),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready)
    );

endmodule

/* test/gate_chk.sv */
// concurrent checks on the merged bus, bound into gate_mux_top
// the grant is observed through m_beat.src, which is driven even while idle

`timescale 1ns/1ns

module gate_chk (
    input logic                clk,
    input logic                reset,
    input gate_pkg::out_beat_t m_beat,
    input logic                m_valid,
    input logic                m_ready,
    input gate_pkg::beat_t     gate_beat0,
    input gate_pkg::beat_t     gate_beat1,
    input logic                gate_valid0,
    input logic                gate_valid1
);
    int   hold_fails = 0;
    int   src_fails = 0;
    int   ready_fails = 0;
    logic in_frame;

    // mirrors the arbiter's frame tracking on the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame <= 1'b0;
        end else if (m_valid && m_ready) begin
            in_frame <= !m_beat.beat.last;
        end
    end

    // ------------------------------------------------------------
    hold_chk: assert property (@(posedge clk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else begin
        hold_fails++;
        $error("m_beat changed while stalled");
    end

    // grant moves after a frame end, or between frames while the bus is idle
    src_chk: assert property (@(posedge clk) disable iff (reset)
        $changed(m_beat.src) |->
            ($past(m_valid && m_ready && m_beat.beat.last) || $past(!m_valid && !in_frame)))
    else begin
        src_fails++;
        $error("source bit changed inside a frame");
    end

    // a gate output moves on only when the bus takes a beat from that channel
    ready_chk: assert property (@(posedge clk) disable iff (reset)
        (!$past(gate_valid0 && !(m_valid && m_ready && !m_beat.src))
            || (gate_valid0 && $stable(gate_beat0)))
        && (!$past(gate_valid1 && !(m_valid && m_ready && m_beat.src))
            || (gate_valid1 && $stable(gate_beat1))))
    else begin
        ready_fails++;
        $error("ready given to a channel without the grant");
    end

endmodule

bind gate_mux_top gate_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .m_beat      (m_beat),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .gate_beat0  (gate_beat0),
    .gate_beat1  (gate_beat1),
    .gate_valid0 (gate_valid0),
    .gate_valid1 (gate_valid1)
);

/* test/tb_gate_mux.sv */
// random frames on both channels with leftovers, short frames, gaps and stalls
// the final permit of each channel keeps last set so the grant can move on
// padding_data is constant for the whole run

`timescale 1ns/1ns

module tb_gate_mux;
    import gate_pkg::*;

    localparam int FRAMES = 24;

    logic        clk = 1'b0;
    logic        reset;
    beat_t       s_beat [2];
    logic        s_valid [2];
    logic        s_ready [2];
    permit_t     s_permit [2];
    logic        s_permit_valid [2];
    logic        s_permit_ready [2];
    data_t       padding_data;
    out_beat_t   m_beat;
    logic        m_valid;
    logic        m_ready;

    beat_t       in_q [2][$];
    permit_t     permit_q [2][$];
    out_beat_t   exp_q [2][$];
    logic [31:0] lfsr_state = 32'hfeab84d9;
    int          errors = 0;
    int          total_beats = 0;
    logic        bus_in_frame = 1'b0;
    logic        bus_src = 1'b0;

    always #5 clk = ~clk;

    gate_mux_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .s_beat0         (s_beat[0]),
        .s_beat1         (s_beat[1]),
        .s_valid0        (s_valid[0]),
        .s_valid1        (s_valid[1]),
        .s_ready0        (s_ready[0]),
        .s_ready1        (s_ready[1]),
        .s_permit0       (s_permit[0]),
        .s_permit1       (s_permit[1]),
        .s_permit_valid0 (s_permit_valid[0]),
        .s_permit_valid1 (s_permit_valid[1]),
        .s_permit_ready0 (s_permit_ready[0]),
        .s_permit_ready1 (s_permit_ready[1]),
        .padding_data    (padding_data),
        .m_beat          (m_beat),
        .m_valid         (m_valid),
        .m_ready         (m_ready)
    );

    // ------------------------------------------------------------
    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // expected bus beat idx of a permit that got n_in input beats
    function automatic out_beat_t expected_beat(input permit_t p, input int ch, input int idx,
                                                input int n_in, input data_t d);
        out_beat_t e;
        int        len;
        len          = int'(p.len);
        e.beat.first = (idx == 0) ? p.first : 1'b0;
        e.beat.last  = (idx == len - 1) ? p.last : 1'b0;
        e.beat.data  = (idx < n_in) ? d : padding_data;
        e.user       = p.user;
        e.src        = (ch == 1);
        return e;
    endfunction

    task automatic plan_frames(input int ch);
        permit_t p;
        beat_t   b;
        int      len;
        int      n_in;
        int      skip_n;
        for (int f = 0; f < FRAMES; f++) begin
            len  = 1 + int'(rand_bits(4));
            n_in = len;
            if (rand_bits(2) == 0) begin
                n_in = 1 + int'(rand_bits(4)) % len;
            end
            skip_n  = (rand_bits(2) == 0) ? 1 + int'(rand_bits(1)) : 0;
            p.first = (rand_bits(2) != 0);
            p.last  = (rand_bits(2) != 0) || (f == FRAMES - 1);
            p.len   = len_t'(len);
            p.user  = user_t'(rand_bits(4));
            permit_q[ch].push_back(p);
            // leftovers ahead of the frame
            for (int i = 0; i < skip_n; i++) begin
                b.first = 1'b0;
                b.last  = (rand_bits(1) != 0);
                b.data  = data_t'(rand_bits(32));
                in_q[ch].push_back(b);
            end
            for (int i = 0; i < len; i++) begin
                b.data = data_t'(rand_bits(32));
                if (i < n_in) begin
                    b.first = (i == 0) || (rand_bits(1) != 0);
                    b.last  = (i == n_in - 1);
                    in_q[ch].push_back(b);
                end
                exp_q[ch].push_back(expected_beat(p, ch, i, n_in, b.data));
            end
            total_beats += skip_n + len;
        end
    endtask

    // ------------------------------------------------------------
    // sources and m_ready change 1 ns after the rising edge
    task automatic drive_inputs();
        logic take_s [2];
        logic take_p [2];
        forever begin
            @(negedge clk);
            for (int ch = 0; ch < 2; ch++) begin
                take_s[ch] = s_valid[ch] && s_ready[ch];
                take_p[ch] = s_permit_valid[ch] && s_permit_ready[ch];
            end
            @(posedge clk);
            #1;
            for (int ch = 0; ch < 2; ch++) begin
                if (take_s[ch]) s_valid[ch] = 1'b0;
                if (!s_valid[ch] && in_q[ch].size() != 0 && rand_bits(2) != 0) begin
                    s_beat[ch]  = in_q[ch].pop_front();
                    s_valid[ch] = 1'b1;
                end
                if (take_p[ch]) s_permit_valid[ch] = 1'b0;
                if (!s_permit_valid[ch] && permit_q[ch].size() != 0 && rand_bits(1) != 0) begin
                    s_permit[ch]       = permit_q[ch].pop_front();
                    s_permit_valid[ch] = 1'b1;
                end
            end
            m_ready = (rand_bits(2) != 0);
        end
    endtask

    task automatic check_beat();
        out_beat_t exp;
        int        ch;
        ch = m_beat.src ? 1 : 0;
        if (bus_in_frame && m_beat.src != bus_src) begin
            errors++;
            $display("[FAIL] %0t: channel %0d beat inside a frame of channel %0d",
                     $time, ch, bus_src);
        end
        bus_in_frame = !m_beat.beat.last;
        bus_src      = m_beat.src;
        if (exp_q[ch].size() == 0) begin
            errors++;
            $display("channel %0d sent a beat at %0t after its last expected beat", ch, $time);
        end else begin
            exp = exp_q[ch].pop_front();
            if (m_beat !== exp) begin
                errors++;
                $display("[FAIL] %0t: channel %0d got %h, expected %h", $time, ch, m_beat, exp);
            end
        end
    endtask

    // scoreboard samples the bus at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && m_valid && m_ready) check_beat();
        end
    end

    initial begin
        @(negedge reset);
        drive_inputs();
    end

    initial begin
        @(negedge reset);
        repeat (200 * total_beats) @(posedge clk);
        $display("timeout after %0d cycles with bus beats still missing", 200 * total_beats);
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    initial begin
        int chk_errors;
        reset        = 1'b1;
        m_ready      = 1'b0;
        padding_data = 32'h5a5a_c3c3;
        for (int ch = 0; ch < 2; ch++) begin
            s_beat[ch]         = '0;
            s_valid[ch]        = 1'b0;
            s_permit[ch]       = '0;
            s_permit_valid[ch] = 1'b0;
        end
        plan_frames(0);
        plan_frames(1);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge clk);
        repeat (5) @(posedge clk);
        if (in_q[0].size() != 0 || in_q[1].size() != 0) begin
            errors++;
            $display("input beats were left unsent at the end of the run");
        end
        chk_errors = u_dut.u_chk.hold_fails + u_dut.u_chk.src_fails + u_dut.u_chk.ready_fails;
        $display("errors: %0d scoreboard, %0d assertion", errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/gate_pkg.sv
hdl/permit_fifo.sv
hdl/stream_gate.sv
hdl/bus_arbiter.sv
hdl/gate_mux_top.sv
test/gate_chk.sv
test/tb_gate_mux.sv

/* Makefile */
# Verilator build of tb_gate_mux with the bound checker

TOP := tb_gate_mux

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee run.log
	grep -q "TB PASSED" run.log

clean:
	rm -rf obj_dir run.log
